/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // word and counter width
    localparam int WORD_W = 32;

    // instruction store
    localparam int MEM_DEPTH = 64;                 // number of slots
    localparam int ADDR_W    = $clog2(MEM_DEPTH);  // load and read address width

    // next address at or above this returns the counter to zero,
    // so the last slot is never reached in sequence
    localparam int WRAP_LIMIT = MEM_DEPTH - 1;

    // opcode field sits in the top bits of the word
    localparam int OPC_W = 6;

    localparam logic [OPC_W-1:0] HALT_OPC = '1;    // all ones stops fetching

    typedef enum logic [OPC_W-1:0] {
        OPC_OTHER = 6'h00,                         // any non-halt value
        OPC_HALT  = HALT_OPC
    } opcode_e;

    typedef enum logic [1:0] {
        ST_RUN  = 2'b00,
        ST_LOAD = 2'b01,
        ST_HALT = 2'b10
    } fetch_state_e;

endpackage

`default_nettype wire

/* src/fetch_control.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_control import fetch_pkg::*; (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_load_en,
    input  wire logic             i_stall,
    input  wire logic [OPC_W-1:0] i_opc,      // opcode of current read word
    output logic                  o_pc_clear,
    output logic                  o_pc_hold,
    output logic                  o_blank,
    output logic                  o_loading,
    output logic                  o_halted
);

    fetch_state_e state_q;    // registered state
    fetch_state_e state_d;
    fetch_state_e state;      // effective state this cycle
    opcode_e      opc_dec;
    logic         run_cycle;
    logic         halt_hit;

    // opcode decode
    always_comb begin
        if (i_opc == HALT_OPC) begin
            opc_dec = OPC_HALT;
        end else begin
            opc_dec = OPC_OTHER;
        end
    end

    // load takes over in the same cycle
    always_comb begin
        if (i_rst) begin
            state = ST_RUN;
        end else if (i_load_en) begin
            state = ST_LOAD;
        end else begin
            state = state_q;
        end
    end

    // the cycle right after a load runs normally
    assign run_cycle = !i_load_en && (state_q != ST_HALT);
    assign halt_hit  = run_cycle && !i_stall && (opc_dec == OPC_HALT);

    always_comb begin
        state_d = ST_RUN;
        if (i_load_en) begin
            state_d = ST_LOAD;
        end else if (state_q == ST_HALT) begin
            state_d = ST_HALT;                // only load or reset leave halt
        end else if (halt_hit) begin
            state_d = ST_HALT;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // clear wins over hold, so they never overlap
    assign o_pc_clear = i_rst || i_load_en;
    assign o_pc_hold  = !o_pc_clear && (i_stall || halt_hit || state == ST_HALT);
    assign o_blank    = i_rst || i_load_en;   // read shows zero while loading

    assign o_loading  = i_load_en;
    assign o_halted   = (state == ST_HALT);

endmodule

`default_nettype wire

/* src/program_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module program_counter import fetch_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_rst,
    input  wire logic              i_clear,        // zero on next edge
    input  wire logic              i_hold,         // keep current value
    input  wire logic              i_jump,         // take jump target
    input  wire logic [WORD_W-1:0] i_jump_target,
    output logic      [WORD_W-1:0] o_pc,
    output logic      [WORD_W-1:0] o_pc_plus1
);

    localparam logic [WORD_W-1:0] WRAP_AT = WORD_W'(WRAP_LIMIT);

    logic [WORD_W-1:0] pc_q;
    logic [WORD_W-1:0] pc_plus1;
    logic [WORD_W-1:0] pc_cand;
    logic [WORD_W-1:0] pc_next;

    assign pc_plus1 = pc_q + WORD_W'(1);              // next-address adder

    // two-way select between sequential and jump
    always_comb begin
        if (i_jump) begin
            pc_cand = i_jump_target;
        end else begin
            pc_cand = pc_plus1;
        end
    end

    // wrap rule, also catches out-of-range jump targets
    always_comb begin
        if (pc_cand >= WRAP_AT) begin
            pc_next = '0;
        end else begin
            pc_next = pc_cand;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || i_clear) begin
            pc_q <= '0;
        end else if (!i_hold) begin
            pc_q <= pc_next;
        end
    end

    assign o_pc       = pc_q;
    assign o_pc_plus1 = pc_plus1;

endmodule

`default_nettype wire

/* src/instruction_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_memory import fetch_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_rst,
    input  wire logic              i_we,
    input  wire logic [ADDR_W-1:0] i_waddr,
    input  wire logic [WORD_W-1:0] i_wdata,
    input  wire logic [ADDR_W-1:0] i_raddr,   // low bits of pc
    input  wire logic              i_blank,   // force read to zero
    output logic      [WORD_W-1:0] o_rdata,
    output logic      [OPC_W-1:0]  o_opc
);

    logic [WORD_W-1:0] mem [MEM_DEPTH];
    logic [WORD_W-1:0] rd_word;

    // whole store is wiped on reset
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    assign rd_word = mem[i_raddr];            // async read

    always_comb begin
        if (i_blank) begin
            o_rdata = '0;
        end else begin
            o_rdata = rd_word;
        end
    end

    // control sees the raw word, even while blanked
    assign o_opc = rd_word[WORD_W-1 -: OPC_W];

endmodule

`default_nettype wire

/* src/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_rst,
    input  wire logic              i_stall,
    input  wire logic              i_jump,
    input  wire logic [WORD_W-1:0] i_jump_target,
    input  wire logic              i_load_en,
    input  wire logic [ADDR_W-1:0] i_load_addr,
    input  wire logic [WORD_W-1:0] i_load_data,
    output logic      [WORD_W-1:0] o_instruction,
    output logic      [WORD_W-1:0] o_pc,
    output logic      [WORD_W-1:0] o_pc_plus1,
    output logic                   o_loading,
    output logic                   o_halted
);

    logic             pc_clear;
    logic             pc_hold;
    logic             blank;
    logic [OPC_W-1:0] opc;
    logic [WORD_W-1:0] pc;

    fetch_control u_control (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_load_en  (i_load_en),
        .i_stall    (i_stall),
        .i_opc      (opc),
        .o_pc_clear (pc_clear),
        .o_pc_hold  (pc_hold),
        .o_blank    (blank),
        .o_loading  (o_loading),
        .o_halted   (o_halted)
    );

    program_counter u_pc (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_clear       (pc_clear),
        .i_hold        (pc_hold),
        .i_jump        (i_jump),
        .i_jump_target (i_jump_target),
        .o_pc          (pc),
        .o_pc_plus1    (o_pc_plus1)
    );

    instruction_memory u_imem (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_we    (i_load_en),
        .i_waddr (i_load_addr),
        .i_wdata (i_load_data),
        .i_raddr (pc[ADDR_W-1:0]),            // counter stays below depth
        .i_blank (blank),
        .o_rdata (o_instruction),
        .o_opc   (opc)
    );

    assign o_pc = pc;

endmodule

`default_nettype wire

/* dv/fetch_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions import fetch_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_rst,
    input  wire logic              i_load_en,
    input  wire logic              i_pc_clear,
    input  wire logic              i_pc_hold,
    input  wire logic              i_loading,
    input  wire logic              i_halted,
    input  wire fetch_state_e      i_state,     // registered control state
    input  wire logic [WORD_W-1:0] i_pc
);

    int fail_count = 0;

    clear_hold_apart: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_pc_clear && i_pc_hold))
        else begin
            fail_count++;
            $error("counter clear and hold are high together");
        end

    halted_in_halt: assert property (@(posedge i_clk) i_halted |-> i_state == ST_HALT)
        else begin
            fail_count++;
            $error("halted flag is high outside the halt state");
        end

    pc_in_range: assert property (@(posedge i_clk) disable iff (i_rst) i_pc < WRAP_LIMIT)
        else begin
            fail_count++;
            $error("program counter reached the wrap limit");
        end

    loading_follows: assert property (@(posedge i_clk) i_loading == i_load_en)
        else begin
            fail_count++;
            $error("loading flag differs from the load enable");
        end

endmodule

`default_nettype wire

/* dv/fetch_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_checker import fetch_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_rst,
    input  wire logic              i_stall,
    input  wire logic              i_jump,
    input  wire logic [WORD_W-1:0] i_jump_target,
    input  wire logic              i_load_en,
    input  wire logic [ADDR_W-1:0] i_load_addr,
    input  wire logic [WORD_W-1:0] i_load_data,
    input  wire logic [WORD_W-1:0] i_instruction,
    input  wire logic [WORD_W-1:0] i_pc,
    input  wire logic [WORD_W-1:0] i_pc_plus1,
    input  wire logic              i_loading,
    input  wire logic              i_halted,
    output int                     o_err_count,
    output int                     o_check_count
);

    logic [WORD_W-1:0] img [MEM_DEPTH];   // expected store contents
    logic [WORD_W-1:0] pc_m;
    logic [WORD_W-1:0] cand;
    logic [WORD_W-1:0] word_m;
    logic              halt_m;
    logic              primed = 1'b0;     // model known after first reset edge

    initial begin
        o_err_count = 0;
        o_check_count = 0;
    end

    task automatic compare(input string name, input logic [WORD_W-1:0] got,
                           input logic [WORD_W-1:0] exp);
        o_check_count++;
        if (got !== exp) begin
            o_err_count++;
            $display("mismatch at %0t ns: %s is %h, model says %h", $time, name, got, exp);
        end
    endtask

    always @(posedge i_clk) begin
        if (primed) begin
            word_m = img[pc_m[ADDR_W-1:0]];
            compare("o_pc", i_pc, pc_m);
            compare("o_pc_plus1", i_pc_plus1, pc_m + 1);
            compare("o_instruction", i_instruction, (i_rst || i_load_en) ? '0 : word_m);
            compare("o_loading", WORD_W'(i_loading), WORD_W'(i_load_en));
            compare("o_halted", WORD_W'(i_halted), WORD_W'(halt_m && !i_rst && !i_load_en));
        end
        // step the model over this edge
        if (i_rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                img[ADDR_W'(i)] = '0;
            end
            pc_m = '0;
            halt_m = 1'b0;
            primed = 1'b1;
        end else if (i_load_en) begin
            img[i_load_addr] = i_load_data;
            pc_m = '0;
            halt_m = 1'b0;
        end else if (!halt_m && !i_stall) begin
            word_m = img[pc_m[ADDR_W-1:0]];
            if (word_m[WORD_W-1 -: OPC_W] == OPC_HALT) begin
                halt_m = 1'b1;                    // pc stays on the halt word
            end else begin
                cand = i_jump ? i_jump_target : pc_m + 1;
                pc_m = (cand >= WRAP_LIMIT) ? '0 : cand;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

    localparam int JS_STEPS   = 200;
    localparam int HALT_STEPS = 20;
    localparam int PLAN_CYCLES = 2 + (MEM_DEPTH + 1 + WRAP_LIMIT) + 1 + (JS_STEPS + 1)
                               + (HALT_STEPS + 3) + 5 + 1;
    localparam int TIMEOUT_CYCLES = PLAN_CYCLES + 50;

    logic              i_clk;
    logic              i_rst;
    logic              i_stall;
    logic              i_jump;
    logic [WORD_W-1:0] i_jump_target;
    logic              i_load_en;
    logic [ADDR_W-1:0] i_load_addr;
    logic [WORD_W-1:0] i_load_data;
    logic [WORD_W-1:0] o_instruction;
    logic [WORD_W-1:0] o_pc;
    logic [WORD_W-1:0] o_pc_plus1;
    logic              o_loading;
    logic              o_halted;

    int                chk_errors;
    int                chk_count;
    int                tb_errors = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                err_mark;
    int                cycles = 0;
    logic [31:0]       lfsr_q;
    logic [WORD_W-1:0] image [MEM_DEPTH];      // words written so far

    fetch_top u_dut (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_stall       (i_stall),
        .i_jump        (i_jump),
        .i_jump_target (i_jump_target),
        .i_load_en     (i_load_en),
        .i_load_addr   (i_load_addr),
        .i_load_data   (i_load_data),
        .o_instruction (o_instruction),
        .o_pc          (o_pc),
        .o_pc_plus1    (o_pc_plus1),
        .o_loading     (o_loading),
        .o_halted      (o_halted)
    );

    fetch_checker u_chk (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_stall       (i_stall),
        .i_jump        (i_jump),
        .i_jump_target (i_jump_target),
        .i_load_en     (i_load_en),
        .i_load_addr   (i_load_addr),
        .i_load_data   (i_load_data),
        .i_instruction (o_instruction),
        .i_pc          (o_pc),
        .i_pc_plus1    (o_pc_plus1),
        .i_loading     (o_loading),
        .i_halted      (o_halted),
        .o_err_count   (chk_errors),
        .o_check_count (chk_count)
    );

    // top level sees control levels, state and counter together
    bind fetch_top fetch_assertions u_asrt (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_load_en  (i_load_en),
        .i_pc_clear (pc_clear),
        .i_pc_hold  (pc_hold),
        .i_loading  (o_loading),
        .i_halted   (o_halted),
        .i_state    (u_control.state_q),
        .i_pc       (pc)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;                  // 4 ns period

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [WORD_W-1:0] rand_word_nonhalt();
        logic [WORD_W-1:0] w;
        w = rand_bits(WORD_W);
        if (w[WORD_W-1 -: OPC_W] == 6'h3f) begin
            w[WORD_W-1] = 1'b0;                // all-ones opcode would halt
        end
        return w;
    endfunction

    function automatic int total_errors();
        return tb_errors + chk_errors + u_dut.u_asrt.fail_count;
    endfunction

    task automatic expect_val(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            tb_errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic begin_test();
        err_mark = total_errors();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == err_mark) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, total_errors() - err_mark);
        end
    endtask

    task automatic idle();
        i_stall = 1'b1;
        i_jump = 1'b0;
        i_load_en = 1'b0;
    endtask

    // while a load runs the fetch side is blanked and parked at 0
    task automatic check_loading();
        expect_val("o_instruction", o_instruction, 0);
        expect_val("o_loading", WORD_W'(o_loading), 1);
        expect_val("o_pc", o_pc, 0);
        expect_val("o_halted", WORD_W'(o_halted), 0);
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        @(negedge i_clk);
        if (i_load_en) begin
            check_loading();
        end
        i_load_en = 1'b1;
        i_load_addr = addr;
        i_load_data = data;
        image[addr] = data;
    endtask

    task automatic end_load();
        @(negedge i_clk);
        check_loading();
        idle();                                // pc sits at 0 for one cycle
    endtask

    initial begin
        logic [WORD_W-1:0] w;
        logic [WORD_W-1:0] cand;
        logic [WORD_W-1:0] exp_pc;
        logic [WORD_W-1:0] halt_word;
        logic [WORD_W-1:0] new_word;
        int                halt_slot;

        lfsr_q = 32'hc581_6b09;
        i_rst = 1'b1;
        i_stall = 1'b1;
        i_jump = 1'b0;
        i_jump_target = '0;
        i_load_en = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        repeat (2) @(negedge i_clk);
        i_rst = 1'b0;

        begin_test();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            write_word(ADDR_W'(i), rand_word_nonhalt());
        end
        end_load();
        for (int i = 0; i < WRAP_LIMIT; i++) begin
            @(negedge i_clk);
            expect_val("o_pc", o_pc, i);
            expect_val("o_pc_plus1", o_pc_plus1, i + 1);
            expect_val("o_instruction", o_instruction, image[ADDR_W'(i)]);
            i_stall = 1'b0;
        end
        end_test("load_read");

        begin_test();
        @(negedge i_clk);
        expect_val("o_pc", o_pc, 0);           // slot 62 steps back to 0
        idle();
        end_test("wrap");

        begin_test();
        exp_pc = '0;
        for (int n = 0; n < JS_STEPS; n++) begin
            @(negedge i_clk);
            expect_val("o_pc", o_pc, exp_pc);
            i_stall = (rand_bits(2) == 0);
            i_jump = (rand_bits(2) == 0);
            i_jump_target = rand_bits(7);      // half of these lie past the limit
            if (!i_stall) begin
                cand = i_jump ? i_jump_target : exp_pc + 1;
                exp_pc = (cand >= WRAP_LIMIT) ? '0 : cand;
            end
        end
        @(negedge i_clk);
        expect_val("o_pc", o_pc, exp_pc);
        idle();
        end_test("jump_stall");

        begin_test();
        halt_slot = 1 + int'(rand_bits(6) % 61);
        w = rand_bits(26);
        halt_word = {6'h3f, w[25:0]};
        write_word(ADDR_W'(halt_slot), halt_word);
        end_load();
        i_stall = 1'b0;
        i_jump = 1'b1;
        i_jump_target = WORD_W'(halt_slot);
        @(negedge i_clk);
        expect_val("o_pc", o_pc, halt_slot);
        expect_val("o_instruction", o_instruction, halt_word);
        expect_val("o_halted", WORD_W'(o_halted), 0);
        i_jump_target = rand_bits(6);          // jump beside the halt is dropped
        for (int n = 0; n < HALT_STEPS; n++) begin
            @(negedge i_clk);
            expect_val("o_pc", o_pc, halt_slot);
            expect_val("o_halted", WORD_W'(o_halted), 1);
            i_stall = (rand_bits(1) != 0);
            i_jump = (rand_bits(1) != 0);
            i_jump_target = rand_bits(7);
        end
        end_test("halt");

        begin_test();
        w = rand_word_nonhalt();
        new_word = rand_word_nonhalt();
        write_word(ADDR_W'(halt_slot), w);
        write_word('0, new_word);
        end_load();
        @(negedge i_clk);
        expect_val("o_pc", o_pc, 0);
        expect_val("o_instruction", o_instruction, new_word);
        expect_val("o_halted", WORD_W'(o_halted), 0);
        expect_val("o_loading", WORD_W'(o_loading), 0);
        i_stall = 1'b0;
        i_jump = 1'b1;
        i_jump_target = WORD_W'(halt_slot);
        @(negedge i_clk);
        expect_val("o_pc", o_pc, halt_slot);
        expect_val("o_instruction", o_instruction, w);
        expect_val("o_halted", WORD_W'(o_halted), 0);
        idle();
        end_test("reload");

        @(negedge i_clk);
        $display("tests %0d, failed %0d, checker compares %0d, errors %0d",
                 tests_run, tests_failed, chk_count, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/fetch_pkg.sv
src/fetch_control.sv
src/program_counter.sv
src/instruction_memory.sv
src/fetch_top.sv
dv/fetch_assertions.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

/* Makefile */
# Verilator build and run for the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test OK

SOURCES := $(wildcard src/*.sv dv/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: compile
	@out="$$(./$(BINARY) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
